/* Bender.yml */
package:
  name: audio_codec

sources:
  - files:
      - codec_pkg.sv
      - codec_timing.sv
      - dac_serializer.sv
      - adc_deserializer.sv
      - audio_codec.sv
  - target: test
    files:
      - tb_audio_codec.sv

/* adc_deserializer.sv */
// capture frame deserializer
`default_nettype none

module adc_deserializer (
	input  logic iCLK_18_4,
	input  logic iRST_N,
	input  codec_pkg::codec_tick_t tick,
	input  logic adc_data,
	output logic cap_valid,
	output codec_pkg::stereo_frame_t cap_frame
);

	// last bit position of a slot
	localparam int bit_last = codec_pkg::sample_w - 1;

	// two flop input sync, far shorter than a bck phase
	logic [1:0] adc_sync;
	logic adc_bit;

	// bits of the current slot
	codec_pkg::sample_t slot_sr;
	codec_pkg::sample_t slot_word;

	// left word kept until the right one completes
	codec_pkg::sample_t hold_left;

	logic word_done;
	// one full left slot seen since reset
	logic armed;

	//////////////////////////////////////////////////////////////////////
	// input sync and bit shift
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			adc_sync <= 2'b00;
		end
		else
		begin
			adc_sync <= {adc_sync[0], adc_data};
		end
	end

	assign adc_bit = adc_sync[1];

	// completed word including the bit sampled this cycle
	assign slot_word = {slot_sr[codec_pkg::sample_w-2:0], adc_bit};

	// LSB sampled at the last rising edge of the slot
	assign word_done = tick.bck_rise &
		(tick.bit_idx == codec_pkg::bit_idx_w'(bit_last));

	// mid bit sample on rising bck
	always_ff @(posedge iCLK_18_4)
	begin
		if (tick.bck_rise)
		begin
			slot_sr <= slot_word;
		end
		if (word_done && tick.left)
		begin
			hold_left <= slot_word;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// frame output
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			armed <= 1'b0;
			cap_valid <= 1'b0;
			cap_frame <= '0;
		end
		else
		begin
			cap_valid <= 1'b0;
			if (word_done && tick.left)
			begin
				armed <= 1'b1;
			end
			// right word closes the frame
			if (word_done && !tick.left && armed)
			begin
				cap_frame.left <= hold_left;
				cap_frame.right <= slot_word;
				cap_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* audio_codec.sv */
// serial audio codec port top level
`default_nettype none

module audio_codec #(
	parameter int ref_clk_hz = 18432000,
	parameter int sample_rate_hz = 8000
) (
	input  logic iCLK_18_4,
	input  logic iRST_N,

	// playback side, one strobe per frame
	input  logic play_valid,
	input  codec_pkg::stereo_frame_t play_frame,

	// capture side, strobe once per frame
	output logic cap_valid,
	output codec_pkg::stereo_frame_t cap_frame,

	// codec pins
	output logic bck,
	output logic lrck,
	output logic dac_data,
	input  logic adc_data
);

	//////////////////////////////////////////////////////////////////////
	// timing controller
	//////////////////////////////////////////////////////////////////////

	// bck edge and slot strobes for both datapaths
	codec_pkg::codec_tick_t tick;

	codec_timing #(
		.ref_clk_hz(ref_clk_hz),
		.sample_rate_hz(sample_rate_hz)
	) i_codec_timing (
		.iCLK_18_4(iCLK_18_4),
		.iRST_N(iRST_N),
		.bck(bck),
		.lrck(lrck),
		.tick(tick)
	);

	//////////////////////////////////////////////////////////////////////
	// playback path
	//////////////////////////////////////////////////////////////////////

	// shifts out on falling bck
	dac_serializer i_dac_serializer (
		.iCLK_18_4(iCLK_18_4),
		.iRST_N(iRST_N),
		.tick(tick),
		.play_valid(play_valid),
		.play_frame(play_frame),
		.dac_data(dac_data)
	);

	//////////////////////////////////////////////////////////////////////
	// capture path
	//////////////////////////////////////////////////////////////////////

	// samples on rising bck
	adc_deserializer i_adc_deserializer (
		.iCLK_18_4(iCLK_18_4),
		.iRST_N(iRST_N),
		.tick(tick),
		.adc_data(adc_data),
		.cap_valid(cap_valid),
		.cap_frame(cap_frame)
	);

endmodule

`default_nettype wire

/* codec_pkg.sv */
// audio codec port shared types
`default_nettype none

package codec_pkg;

	//////////////////////////////////////////////////////////////////////
	// sample geometry
	//////////////////////////////////////////////////////////////////////

	// bits per sample, MSB sent first
	parameter int sample_w = 16;

	// one stereo frame, left slot then right slot
	localparam int frame_w = 2 * sample_w;

	// bit position counter width within a slot
	localparam int bit_idx_w = $clog2(sample_w);

	// single signed audio sample
	typedef logic signed [sample_w-1:0] sample_t;

	// left sits in the upper half so the frame shifts out left first
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_frame_t;

	//////////////////////////////////////////////////////////////////////
	// timing strobes from the controller
	//////////////////////////////////////////////////////////////////////

	// all pulses are one iCLK_18_4 cycle wide
	typedef struct packed {
		// bck goes low at the end of this cycle
		logic bck_fall;
		// bck goes high at the end of this cycle
		logic bck_rise;
		// falling edge that opens a new slot
		logic slot_start;
		// slot start that opens a left slot
		logic frame_start;
		// current slot is left
		logic left;
		// bit within slot, 0 is MSB
		logic [bit_idx_w-1:0] bit_idx;
	} codec_tick_t;

endpackage

`default_nettype wire

/* codec_timing.sv */
// codec bit and word clock controller
`default_nettype none

module codec_timing #(
	parameter int ref_clk_hz = 18432000,
	parameter int sample_rate_hz = 8000
) (
	input  logic iCLK_18_4,
	input  logic iRST_N,
	output logic bck,
	output logic lrck,
	output codec_pkg::codec_tick_t tick
);

	//////////////////////////////////////////////////////////////////////
	// divider constants
	//////////////////////////////////////////////////////////////////////

	// ref clock cycles per bck phase
	// 36 for 18.432 MHz and 8 kHz
	localparam int bck_half = ref_clk_hz / (sample_rate_hz * codec_pkg::sample_w * 4);

	// counter must hold bck_half-1, keep at least one bit
	localparam int div_w = (bck_half > 1) ? $clog2(bck_half) : 1;

	// last bit position of a slot
	localparam int bit_last = codec_pkg::sample_w - 1;

	logic [div_w-1:0] div_cnt;
	logic div_end;

	logic [codec_pkg::bit_idx_w-1:0] bit_cnt;

	// edge decodes, one cycle ahead of the pin change
	logic fall_now;
	logic rise_now;
	logic slot_wrap;

	//////////////////////////////////////////////////////////////////////
	// bck generator
	//////////////////////////////////////////////////////////////////////

	assign div_end = (div_cnt == div_w'(bck_half - 1));

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			div_cnt <= '0;
			bck <= 1'b0;
		end
		else if (div_end)
		begin
			// end of a phase, flip the pin
			div_cnt <= '0;
			bck <= ~bck;
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// bck high now means the toggle takes it low
	assign fall_now = div_end & bck;
	assign rise_now = div_end & ~bck;

	// falling edge after the LSB of a slot
	assign slot_wrap = fall_now & (bit_cnt == codec_pkg::bit_idx_w'(bit_last));

	//////////////////////////////////////////////////////////////////////
	// bit counter and lrck
	//////////////////////////////////////////////////////////////////////

	// lrck high is left, starts low so first slot is right
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			bit_cnt <= '0;
			lrck <= 1'b0;
		end
		else if (fall_now)
		begin
			if (slot_wrap)
			begin
				// new slot, swap channel on the same bck edge
				bit_cnt <= '0;
				lrck <= ~lrck;
			end
			else
			begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// strobe bundle
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		tick.bck_fall = fall_now;
		tick.bck_rise = rise_now;
		tick.slot_start = slot_wrap;
		// leaving a right slot means a left slot opens
		tick.frame_start = slot_wrap & ~lrck;
		tick.left = lrck;
		tick.bit_idx = bit_cnt;
	end

endmodule

`default_nettype wire

/* dac_serializer.sv */
// playback frame serializer
`default_nettype none

module dac_serializer (
	input  logic iCLK_18_4,
	input  logic iRST_N,
	input  codec_pkg::codec_tick_t tick,
	input  logic play_valid,
	input  codec_pkg::stereo_frame_t play_frame,
	output logic dac_data
);

	//////////////////////////////////////////////////////////////////////
	// pending frame
	//////////////////////////////////////////////////////////////////////

	// frame waiting for the next left slot
	codec_pkg::stereo_frame_t pending;

	// frame being shifted, current bit at the top
	logic [codec_pkg::frame_w-1:0] shifter;

	// no back-pressure, newest strobe overwrites
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			pending <= '0;
		end
		else if (play_valid)
		begin
			pending <= play_frame;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// shift register
	//////////////////////////////////////////////////////////////////////

	// load at frame start, so the order stays left then right
	// even when playback begins in the middle of a frame
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			shifter <= '0;
		end
		else if (tick.frame_start)
		begin
			// left MSB is on the pin once bck has fallen
			shifter <= pending;
		end
		else if (tick.bck_fall)
		begin
			// next bit, zeros fill behind
			shifter <= {shifter[codec_pkg::frame_w-2:0], 1'b0};
		end
	end

	// pin comes straight off the shifter flop
	// so it changes together with the falling bck
	assign dac_data = shifter[codec_pkg::frame_w-1];

endmodule

`default_nettype wire

/* project.f */
codec_pkg.sv
codec_timing.sv
dac_serializer.sv
adc_deserializer.sv
audio_codec.sv
tb_audio_codec.sv

/* tb_audio_codec.sv */
// audio codec port testbench
`default_nettype none

module tb_audio_codec;

	//////////////////////////////////////////////////////////////////////
	// run constants
	//////////////////////////////////////////////////////////////////////

	localparam int ref_clk_hz = 18432000;
	localparam int sample_rate_hz = 8000;
	localparam int sample_w = codec_pkg::sample_w;
	// ref cycles per bck phase, rate formula
	localparam int bck_half = ref_clk_hz / (sample_rate_hz * sample_w * 4);
	// one lrck phase and one stereo frame
	localparam int slot_cycles = sample_w * 2 * bck_half;
	localparam int frame_cycles = 4 * sample_w * bck_half;
	localparam int n_rows = 12;
	localparam int watchdog_cycles = (n_rows + 4) * frame_cycles * 2;

	// one table row, stimulus and the frame it must come back as
	typedef struct packed {
		codec_pkg::stereo_frame_t stim;
		codec_pkg::stereo_frame_t expect_frame;
	} row_t;

	logic iCLK_18_4;
	logic iRST_N;
	logic play_valid;
	codec_pkg::stereo_frame_t play_frame;
	logic cap_valid;
	codec_pkg::stereo_frame_t cap_frame;
	logic bck;
	logic lrck;
	logic dac_data;
	wire adc_data;

	// loopback select and the direct adc driver
	logic loop_en;
	logic adc_drive;
	logic adc_next;
	codec_pkg::stereo_frame_t adc_src;
	// dac bits rebuilt at rising bck
	codec_pkg::stereo_frame_t dac_seen;

	row_t stim_table [n_rows];
	codec_pkg::stereo_frame_t exp_q [$];
	logic [31:0] lcg_state;
	int err_value = 0;
	int err_timing = 0;

	// pin monitor state
	logic prev_bck;
	logic prev_lrck;
	logic prev_cap;
	logic bck_started;
	logic lrck_started;
	int bck_phase;
	int lrck_phase;
	int fall_cnt;
	int bit_pos;
	int run_cycles;

	assign adc_data = loop_en ? dac_data : adc_drive;

	audio_codec #(
		.ref_clk_hz(ref_clk_hz),
		.sample_rate_hz(sample_rate_hz)
	) i_audio_codec (
		.iCLK_18_4(iCLK_18_4),
		.iRST_N(iRST_N),
		.play_valid(play_valid),
		.play_frame(play_frame),
		.cap_valid(cap_valid),
		.cap_frame(cap_frame),
		.bck(bck),
		.lrck(lrck),
		.dac_data(dac_data),
		.adc_data(adc_data)
	);

	initial
	begin
		iCLK_18_4 = 1'b0;
		forever #20 iCLK_18_4 = ~iCLK_18_4;
	end

	initial
	begin : watchdog
		repeat (watchdog_cycles) @(posedge iCLK_18_4);
		$display("timeout, test did not end within %0d clock cycles", watchdog_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic fill_table();
		int i;
		// full scale, zero, alternating bits, then pseudo random
		stim_table[0].stim = {16'h7fff, 16'h7fff};
		stim_table[1].stim = {16'h8000, 16'h8000};
		stim_table[2].stim = {16'h0000, 16'h0000};
		stim_table[3].stim = {16'haaaa, 16'h5555};
		stim_table[4].stim = {16'h5555, 16'haaaa};
		stim_table[5].stim = {16'h7fff, 16'h8000};
		for (i = 6; i < n_rows; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			stim_table[i].stim = lcg_state;
		end
		// loopback returns the frame unchanged
		for (i = 0; i < n_rows; i++)
			stim_table[i].expect_frame = stim_table[i].stim;
	endtask

	task automatic send_frame(input codec_pkg::stereo_frame_t f);
		@(posedge iCLK_18_4);
		play_valid <= 1'b1;
		play_frame <= f;
		@(posedge iCLK_18_4);
		play_valid <= 1'b0;
	endtask

	task automatic wait_capture();
		@(negedge iCLK_18_4);
		while (!cap_valid)
			@(negedge iCLK_18_4);
	endtask

	task automatic check_word(input string name, input codec_pkg::sample_t got,
		input codec_pkg::sample_t expected);
		assert (got == expected)
		else
		begin
			$display("ERR %s got %h expected %h", name, got, expected);
			err_value++;
		end
	endtask

	task automatic check_capture();
		codec_pkg::stereo_frame_t expected;
		expected = exp_q.pop_front();
		check_word("cap_frame.left", cap_frame.left, expected.left);
		check_word("cap_frame.right", cap_frame.right, expected.right);
	endtask

	//////////////////////////////////////////////////////////////////////
	// pin monitor, samples at the falling clock edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge iCLK_18_4)
	begin : monitor
		logic fell;
		logic rose;
		fell = prev_bck & ~bck;
		rose = ~prev_bck & bck;
		if (!iRST_N)
		begin
			// time zero clock edge comes before reset reaches the flops
			if ($time > 0)
			begin
				assert (!bck && !lrck && !dac_data && !cap_valid)
				else
				begin
					$display("codec pins or cap_valid not idle during reset");
					err_timing++;
				end
			end
			bck_started = 1'b0;
			lrck_started = 1'b0;
			bck_phase = 0;
			lrck_phase = 0;
			fall_cnt = 0;
			bit_pos = 0;
			run_cycles = 0;
			adc_next = 1'b0;
		end
		else
		begin
			run_cycles++;
			// idle until bck first toggles
			if (!bck_started && !bck)
				assert (!lrck && !dac_data && !cap_valid)
				else
				begin
					$display("lrck, dac_data or cap_valid active before first bck toggle");
					err_timing++;
				end
			if (bck != prev_bck)
			begin
				if (bck_started)
					assert (bck_phase == bck_half)
					else
					begin
						$display("bck phase lasted %0d cycles instead of %0d", bck_phase,
							bck_half);
						err_timing++;
					end
				bck_started = 1'b1;
				bck_phase = 1;
			end
			else
				bck_phase++;
			if (fell)
				fall_cnt++;
			if (lrck != prev_lrck)
			begin
				assert (fell)
				else
				begin
					$display("lrck changed outside a falling bck edge");
					err_timing++;
				end
				if (lrck_started)
					assert (fall_cnt == sample_w && lrck_phase == slot_cycles)
					else
					begin
						$display("lrck phase held %0d falling edges in %0d cycles", fall_cnt,
							lrck_phase);
						err_timing++;
					end
				lrck_started = 1'b1;
				lrck_phase = 1;
				fall_cnt = 0;
				bit_pos = 0;
			end
			else
			begin
				lrck_phase++;
				if (fell)
					bit_pos++;
			end
			// mid bit, dac pin is settled
			if (rose && lrck)
				dac_seen.left[sample_w-1-bit_pos] = dac_data;
			else if (rose)
				dac_seen.right[sample_w-1-bit_pos] = dac_data;
			if (cap_valid)
				assert (run_cycles >= frame_cycles && !prev_cap)
				else
				begin
					$display("cap_valid too early or wider than one cycle");
					err_timing++;
				end
			adc_next = lrck ? adc_src.left[sample_w-1-bit_pos] :
				adc_src.right[sample_w-1-bit_pos];
		end
		prev_bck = bck;
		prev_lrck = lrck;
		prev_cap = cap_valid;
	end

	// new adc bit one cycle after bck falls
	always @(posedge iCLK_18_4)
	begin
		adc_drive <= adc_next;
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin : main
		int r;
		codec_pkg::stereo_frame_t frame_a;
		codec_pkg::stereo_frame_t frame_b;
		iRST_N = 1'b0;
		play_valid = 1'b0;
		play_frame = '0;
		loop_en = 1'b0;
		adc_drive = 1'b0;
		adc_src = '0;
		lcg_state = 32'd30205;
		fill_table();
		repeat (8) @(posedge iCLK_18_4);
		iRST_N <= 1'b1;
		loop_en <= 1'b1;

		// first capture holds the idle frame
		wait_capture();
		for (r = 0; r < n_rows; r++)
		begin
			send_frame(stim_table[r].stim);
			exp_q.push_back(stim_table[r].expect_frame);
			wait_capture();
			check_capture();
		end

		// capture alone, loopback broken
		lcg_state = lcg_next(lcg_state);
		adc_src = lcg_state;
		lcg_state = lcg_next(lcg_state);
		frame_a = lcg_state;
		@(posedge iCLK_18_4);
		loop_en <= 1'b0;
		send_frame(frame_a);
		exp_q.push_back(adc_src);
		wait_capture();
		check_capture();
		@(posedge iCLK_18_4);
		check_word("dac_data.left", dac_seen.left, frame_a.left);
		check_word("dac_data.right", dac_seen.right, frame_a.right);

		// two strobes before frame start, second one is sent
		loop_en <= 1'b1;
		lcg_state = lcg_next(lcg_state);
		frame_a = lcg_state;
		lcg_state = lcg_next(lcg_state);
		frame_b = lcg_state;
		if (frame_b == frame_a)
			frame_b = ~frame_a;
		send_frame(frame_a);
		send_frame(frame_b);
		exp_q.push_back(frame_b);
		wait_capture();
		check_capture();

		$display("checks done, %0d value errors, %0d timing errors", err_value, err_timing);
		if (err_value == 0 && err_timing == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
